// ==== common/dds_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared definitions for the DDS sweep controller
// holds register addresses, init words, the sweep record
// layout, the serial frame type and default parameter values
// every block refers to these as dds_pkg::name
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package dds_pkg;

	// longest serial frame is one full sweep record
	localparam int FRAME_MAX_BITS = 184;

	// register addresses on the DDS serial port
	localparam logic [7:0] ADDR_RAMP_LIMIT = 8'h0b;
	localparam logic [7:0] ADDR_RAMP_STEP = 8'h0c;
	localparam logic [7:0] ADDR_RAMP_RATE = 8'h0d;
	localparam logic [7:0] ADDR_CFR1 = 8'h00;
	localparam logic [7:0] ADDR_CFR2 = 8'h01;
	localparam logic [7:0] ADDR_CFR3 = 8'h02;
	localparam logic [7:0] ADDR_AUX_DAC = 8'h03;

	// CFR1 bit 12 clears the digital ramp accumulator on update
	localparam logic [31:0] CFR1_CLEAR_WORD = 32'h0000_1000;
	localparam logic [31:0] CFR1_RUN_WORD = 32'h0000_0000;
	// digital ramp mode on, parallel data clock off
	localparam logic [31:0] CFR2_WORD = 32'h0048_0020;
	// high REFCLK_OUT drive, VCO5, input divider bypassed, PLL on with N = 100
	localparam logic [31:0] CFR3_WORD = 32'h353f_c1c8;
	// full scale current as low as it goes
	localparam logic [31:0] AUX_DAC_WORD = 32'h0000_0000;

	// a step of all ones marks the ramp direction that is not used
	localparam logic [31:0] STEP_MAX = 32'hffff_ffff;

	// defaults for the top level parameters
	localparam int DEF_SWEEP_DEPTH = 20;
	localparam int DEF_IO_RESET_CYCLES = 5;
	localparam int DEF_DR_PREP_CYCLES = 8;

	// one sweep as it goes out on sdio, first field is sent first
	typedef struct packed {
		logic [7:0] limit_addr;
		logic [31:0] upper_limit;
		logic [31:0] lower_limit;
		logic [7:0] step_addr;
		logic [31:0] dec_step;
		logic [31:0] inc_step;
		logic [7:0] rate_addr;
		logic [15:0] dec_rate;
		logic [15:0] inc_rate;
	} sweep_record_t;

	// a serial message for the shifter
	// bits are left aligned so bit FRAME_MAX_BITS-1 goes out first
	typedef struct packed {
		logic [FRAME_MAX_BITS-1:0] bits;
		logic [7:0] nbits;
		logic update;
	} dds_frame_t;

endpackage

// ==== serial/dds_serial_shifter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// serial writer for the DDS register port
// sends nbits of a frame most significant bit first, two clock
// cycles per bit, then pulses io_update if the frame asks for it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dds_serial_shifter (
	input logic RABBIT_CLOK,
	input logic reset_flag,
	input logic shift_start,
	input dds_pkg::dds_frame_t shift_frame,
	output logic sdio,
	output logic sclk,
	output logic io_update,
	output logic shift_done
);

	logic [dds_pkg::FRAME_MAX_BITS-1:0] shreg;
	logic [7:0] bits_left;
	logic upd_q;
	logic busy;
	// high when the next cycle raises sclk on the bit already on sdio
	logic phase;

	// remaining bits and the update request of the frame in flight
	always_ff @(posedge RABBIT_CLOK)
	begin
		if (shift_start && !busy)
		begin
			shreg <= shift_frame.bits << 1;
			upd_q <= shift_frame.update;
		end
		else if (busy && !phase && (bits_left != '0))
		begin
			shreg <= shreg << 1;
		end
	end

	always_ff @(posedge RABBIT_CLOK)
	begin
		if (reset_flag)
		begin
			busy <= 1'b0;
			phase <= 1'b0;
			bits_left <= '0;
			sdio <= 1'b0;
			sclk <= 1'b0;
			io_update <= 1'b0;
			shift_done <= 1'b0;
		end
		else
		begin
			io_update <= 1'b0;
			shift_done <= 1'b0;
			if (!busy)
			begin
				if (shift_start)
				begin
					// the first bit sits on sdio with sclk low
					sdio <= shift_frame.bits[dds_pkg::FRAME_MAX_BITS-1];
					sclk <= 1'b0;
					bits_left <= shift_frame.nbits - 8'd1;
					phase <= 1'b1;
					busy <= 1'b1;
				end
			end
			else if (phase)
			begin
				// the chip samples sdio on this rising edge
				sclk <= 1'b1;
				phase <= 1'b0;
			end
			else if (bits_left == '0)
			begin
				// the last bit was clocked in and the frame ends here
				sclk <= 1'b0;
				sdio <= 1'b0;
				busy <= 1'b0;
				io_update <= upd_q;
				shift_done <= 1'b1;
			end
			else
			begin
				sclk <= 1'b0;
				sdio <= shreg[dds_pkg::FRAME_MAX_BITS-1];
				bits_left <= bits_left - 1'b1;
				phase <= 1'b1;
			end
		end
	end

	// a start while a frame is still going out would be lost
	a_start_idle: assert property (@(posedge RABBIT_CLOK) disable iff (reset_flag)
		shift_start |-> !busy);

endmodule

// ==== serial/serial_port_arbiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shares the one DDS serial port between init and playback
// init has fixed priority, the owner keeps the port until
// the shifter reports its frame done
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module serial_port_arbiter (
	input logic RABBIT_CLOK,
	input logic reset_flag,
	input logic init_req,
	input dds_pkg::dds_frame_t init_frame,
	input logic play_req,
	input dds_pkg::dds_frame_t play_frame,
	input logic shift_done,
	output logic init_grant,
	output logic play_grant,
	output logic init_done,
	output logic play_done,
	output logic shift_start,
	output dds_pkg::dds_frame_t shift_frame
);

	typedef enum logic [1:0] {OWN_NONE, OWN_INIT, OWN_PLAY} owner_t;

	// also tells whether the shifter is busy
	owner_t owner;

	// done goes back only to whoever owns the frame on the wire
	assign init_done = shift_done && (owner == OWN_INIT);
	assign play_done = shift_done && (owner == OWN_PLAY);

	always_ff @(posedge RABBIT_CLOK)
	begin
		if (reset_flag)
		begin
			owner <= OWN_NONE;
			init_grant <= 1'b0;
			play_grant <= 1'b0;
			shift_start <= 1'b0;
		end
		else
		begin
			init_grant <= 1'b0;
			play_grant <= 1'b0;
			shift_start <= 1'b0;
			if (owner == OWN_NONE)
			begin
				if (init_req)
				begin
					owner <= OWN_INIT;
					init_grant <= 1'b1;
					shift_start <= 1'b1;
					shift_frame <= init_frame;
				end
				else if (play_req)
				begin
					owner <= OWN_PLAY;
					play_grant <= 1'b1;
					shift_start <= 1'b1;
					shift_frame <= play_frame;
				end
			end
			else if (shift_done)
			begin
				owner <= OWN_NONE;
			end
		end
	end

	// the shifter only finishes frames that were granted here
	a_done_owned: assert property (@(posedge RABBIT_CLOK) disable iff (reset_flag)
		shift_done |-> (owner != OWN_NONE));

endmodule

// ==== hdl/sweep_store.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sweep record FIFO between the host and the player
// the host writes only while it holds a credit and gets one
// back per record the player pops
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sweep_store #(
	parameter int SWEEP_DEPTH = 20
) (
	input logic RABBIT_CLOK,
	input logic reset_flag,
	input logic host_valid,
	input dds_pkg::sweep_record_t host_record,
	input logic rec_pop,
	output logic host_credit,
	output logic rec_ready,
	output dds_pkg::sweep_record_t rec_head
);

	localparam int PTR_W = (SWEEP_DEPTH > 1) ? $clog2(SWEEP_DEPTH) : 1;
	localparam int CNT_W = $clog2(SWEEP_DEPTH + 1);

	dds_pkg::sweep_record_t mem [SWEEP_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// the oldest record is always visible to the player
	assign rec_ready = (count != '0);
	assign rec_head = mem[rd_ptr];

	// record storage, written whenever the host presents a record
	always_ff @(posedge RABBIT_CLOK)
	begin
		if (host_valid)
		begin
			mem[wr_ptr] <= host_record;
		end
	end

	always_ff @(posedge RABBIT_CLOK)
	begin
		if (reset_flag)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			host_credit <= 1'b0;
		end
		else
		begin
			// every freed slot goes straight back to the host as one credit
			host_credit <= rec_pop;
			if (host_valid)
			begin
				wr_ptr <= (wr_ptr == PTR_W'(SWEEP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rec_pop)
			begin
				rd_ptr <= (rd_ptr == PTR_W'(SWEEP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// a write and a pop in the same cycle leave the count alone
			if (host_valid && !rec_pop)
			begin
				count <= count + 1'b1;
			end
			else if (rec_pop && !host_valid)
			begin
				count <= count - 1'b1;
			end
		end
	end

	// the credit loop must keep the host from overrunning the buffer
	a_no_write_full: assert property (@(posedge RABBIT_CLOK) disable iff (reset_flag)
		host_valid |-> (count != CNT_W'(SWEEP_DEPTH)) || rec_pop);

	// the player only pops what is there
	a_no_pop_empty: assert property (@(posedge RABBIT_CLOK) disable iff (reset_flag)
		rec_pop |-> (count != '0));

endmodule

// ==== hdl/init_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DDS initialization after init_trigger
// pulses io_reset, then requests the six setup frames one
// after another through the serial port arbiter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module init_sequencer #(
	parameter int IO_RESET_CYCLES = 5
) (
	input logic RABBIT_CLOK,
	input logic reset_flag,
	input logic init_trigger,
	input logic init_grant,
	input logic init_done,
	output logic io_reset,
	output logic init_busy,
	output logic init_req,
	output dds_pkg::dds_frame_t init_frame
);

	localparam int CNT_W = (IO_RESET_CYCLES > 1) ? $clog2(IO_RESET_CYCLES + 1) : 1;

	typedef enum logic [1:0] {S_IDLE, S_PULSE, S_REQ, S_SEND} state_t;

	state_t state;
	logic [CNT_W-1:0] pulse_cnt;
	logic [2:0] frame_idx;

	// a 40 bit register write, address then word, left aligned in the frame
	function automatic dds_pkg::dds_frame_t reg_frame(input logic [7:0] addr,
		input logic [31:0] word, input logic upd);
		dds_pkg::dds_frame_t f;
		f.bits = {addr, word, {(dds_pkg::FRAME_MAX_BITS - 40){1'b0}}};
		f.nbits = 8'd40;
		f.update = upd;
		return f;
	endfunction

	// frame contents follow the index, the first one zeroes both ramp limits
	always_comb
	begin
		case (frame_idx)
			3'd0:
			begin
				init_frame.bits = {dds_pkg::ADDR_RAMP_LIMIT, 64'h0,
					{(dds_pkg::FRAME_MAX_BITS - 72){1'b0}}};
				init_frame.nbits = 8'd72;
				init_frame.update = 1'b0;
			end
			3'd1: init_frame = reg_frame(dds_pkg::ADDR_CFR1, dds_pkg::CFR1_CLEAR_WORD, 1'b0);
			3'd2: init_frame = reg_frame(dds_pkg::ADDR_CFR2, dds_pkg::CFR2_WORD, 1'b0);
			3'd3: init_frame = reg_frame(dds_pkg::ADDR_CFR3, dds_pkg::CFR3_WORD, 1'b0);
			// this update loads the setup and clears the ramp accumulator
			3'd4: init_frame = reg_frame(dds_pkg::ADDR_AUX_DAC, dds_pkg::AUX_DAC_WORD, 1'b1);
			// with the clear bit dropped the accumulator can ramp again
			default: init_frame = reg_frame(dds_pkg::ADDR_CFR1, dds_pkg::CFR1_RUN_WORD, 1'b1);
		endcase
	end

	always_ff @(posedge RABBIT_CLOK)
	begin
		if (reset_flag)
		begin
			state <= S_IDLE;
			pulse_cnt <= '0;
			frame_idx <= '0;
			io_reset <= 1'b0;
			init_busy <= 1'b0;
			init_req <= 1'b0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					// a trigger while busy never reaches this state
					if (init_trigger)
					begin
						io_reset <= 1'b1;
						init_busy <= 1'b1;
						frame_idx <= '0;
						pulse_cnt <= CNT_W'(IO_RESET_CYCLES - 1);
						state <= S_PULSE;
					end
				end
				S_PULSE:
				begin
					if (pulse_cnt == '0)
					begin
						io_reset <= 1'b0;
						init_req <= 1'b1;
						state <= S_REQ;
					end
					else
					begin
						pulse_cnt <= pulse_cnt - 1'b1;
					end
				end
				S_REQ:
				begin
					// hold the request and frame until the arbiter takes them
					if (init_grant)
					begin
						init_req <= 1'b0;
						state <= S_SEND;
					end
				end
				default:
				begin
					if (init_done)
					begin
						if (frame_idx == 3'd5)
						begin
							init_busy <= 1'b0;
							state <= S_IDLE;
						end
						else
						begin
							frame_idx <= frame_idx + 1'b1;
							init_req <= 1'b1;
							state <= S_REQ;
						end
					end
				end
			endcase
		end
	end

endmodule

// ==== hdl/sweep_player.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sweep playback
// each sweep_trig pops the oldest record, sends it as one
// 184 bit frame with update, and then steers dr_ctl through
// its preparation and final levels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sweep_player #(
	parameter int DR_PREP_CYCLES = 8
) (
	input logic RABBIT_CLOK,
	input logic reset_flag,
	input logic sweep_trig,
	input logic rec_ready,
	input dds_pkg::sweep_record_t rec_head,
	input logic play_grant,
	input logic play_done,
	output logic rec_pop,
	output logic play_req,
	output dds_pkg::dds_frame_t play_frame,
	output logic dr_ctl,
	output logic sweep_busy
);

	localparam int CNT_W = (DR_PREP_CYCLES > 1) ? $clog2(DR_PREP_CYCLES + 1) : 1;

	typedef enum logic [1:0] {S_IDLE, S_REQ, S_SEND, S_PREP} state_t;

	state_t state;
	dds_pkg::sweep_record_t rec_q;
	logic [CNT_W-1:0] prep_cnt;
	logic upward;

	// a trigger only counts when idle with something stored
	assign rec_pop = (state == S_IDLE) && sweep_trig && rec_ready;

	// the whole record goes out in one message, then the chip updates
	assign play_frame.bits = rec_q;
	assign play_frame.nbits = 8'(dds_pkg::FRAME_MAX_BITS);
	assign play_frame.update = 1'b1;

	// the host parks the unused direction at the maximum step,
	// so a maxed decrement step means the sweep runs upward
	assign upward = (rec_q.dec_step == dds_pkg::STEP_MAX);

	// the popped record is held here for the length of the sweep
	always_ff @(posedge RABBIT_CLOK)
	begin
		if (rec_pop)
		begin
			rec_q <= rec_head;
		end
	end

	always_ff @(posedge RABBIT_CLOK)
	begin
		if (reset_flag)
		begin
			state <= S_IDLE;
			prep_cnt <= '0;
			play_req <= 1'b0;
			dr_ctl <= 1'b0;
			sweep_busy <= 1'b0;
		end
		else
		begin
			case (state)
				S_IDLE:
				begin
					if (rec_pop)
					begin
						play_req <= 1'b1;
						sweep_busy <= 1'b1;
						state <= S_REQ;
					end
				end
				S_REQ:
				begin
					if (play_grant)
					begin
						play_req <= 1'b0;
						state <= S_SEND;
					end
				end
				S_SEND:
				begin
					// done comes with io_update and the preparation level follows it
					if (play_done)
					begin
						dr_ctl <= !upward;
						prep_cnt <= CNT_W'(DR_PREP_CYCLES - 1);
						state <= S_PREP;
					end
				end
				default:
				begin
					if (prep_cnt == '0)
					begin
						// final level is the opposite one and stays until the next sweep
						dr_ctl <= upward;
						sweep_busy <= 1'b0;
						state <= S_IDLE;
					end
					else
					begin
						prep_cnt <= prep_cnt - 1'b1;
					end
				end
			endcase
		end
	end

	// a done only ever answers the frame this player has on the wire
	a_done_sending: assert property (@(posedge RABBIT_CLOK) disable iff (reset_flag)
		play_done |-> (state == S_SEND));

endmodule

// ==== hdl/dds_sweep_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top of the DDS sweep controller
// the host fills the sweep store under credit flow control,
// init and sweep playback share the serial port through
// the arbiter, and all parameters are set here
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dds_sweep_top #(
	parameter int SWEEP_DEPTH = dds_pkg::DEF_SWEEP_DEPTH,
	parameter int IO_RESET_CYCLES = dds_pkg::DEF_IO_RESET_CYCLES,
	parameter int DR_PREP_CYCLES = dds_pkg::DEF_DR_PREP_CYCLES
) (
	input logic RABBIT_CLOK,
	input logic reset_flag,
	input logic host_valid,
	input dds_pkg::sweep_record_t host_record,
	input logic init_trigger,
	input logic sweep_trig,
	output logic host_credit,
	output logic sdio,
	output logic sclk,
	output logic io_update,
	output logic io_reset,
	output logic dr_ctl,
	output logic init_busy,
	output logic sweep_busy
);

	// store to player
	logic rec_ready;
	logic rec_pop;
	dds_pkg::sweep_record_t rec_head;

	// requesters to arbiter
	logic init_req;
	logic init_grant;
	logic init_done;
	dds_pkg::dds_frame_t init_frame;
	logic play_req;
	logic play_grant;
	logic play_done;
	dds_pkg::dds_frame_t play_frame;

	// arbiter to shifter
	logic shift_start;
	logic shift_done;
	dds_pkg::dds_frame_t shift_frame;

	sweep_store #(
		.SWEEP_DEPTH(SWEEP_DEPTH)
	) u_store (
		.RABBIT_CLOK(RABBIT_CLOK),
		.reset_flag(reset_flag),
		.host_valid(host_valid),
		.host_record(host_record),
		.rec_pop(rec_pop),
		.host_credit(host_credit),
		.rec_ready(rec_ready),
		.rec_head(rec_head)
	);

	init_sequencer #(
		.IO_RESET_CYCLES(IO_RESET_CYCLES)
	) u_init (
		.RABBIT_CLOK(RABBIT_CLOK),
		.reset_flag(reset_flag),
		.init_trigger(init_trigger),
		.init_grant(init_grant),
		.init_done(init_done),
		.io_reset(io_reset),
		.init_busy(init_busy),
		.init_req(init_req),
		.init_frame(init_frame)
	);

	sweep_player #(
		.DR_PREP_CYCLES(DR_PREP_CYCLES)
	) u_player (
		.RABBIT_CLOK(RABBIT_CLOK),
		.reset_flag(reset_flag),
		.sweep_trig(sweep_trig),
		.rec_ready(rec_ready),
		.rec_head(rec_head),
		.play_grant(play_grant),
		.play_done(play_done),
		.rec_pop(rec_pop),
		.play_req(play_req),
		.play_frame(play_frame),
		.dr_ctl(dr_ctl),
		.sweep_busy(sweep_busy)
	);

	serial_port_arbiter u_arb (
		.RABBIT_CLOK(RABBIT_CLOK),
		.reset_flag(reset_flag),
		.init_req(init_req),
		.init_frame(init_frame),
		.play_req(play_req),
		.play_frame(play_frame),
		.shift_done(shift_done),
		.init_grant(init_grant),
		.play_grant(play_grant),
		.init_done(init_done),
		.play_done(play_done),
		.shift_start(shift_start),
		.shift_frame(shift_frame)
	);

	dds_serial_shifter u_shifter (
		.RABBIT_CLOK(RABBIT_CLOK),
		.reset_flag(reset_flag),
		.shift_start(shift_start),
		.shift_frame(shift_frame),
		.sdio(sdio),
		.sclk(sclk),
		.io_update(io_update),
		.shift_done(shift_done)
	);

endmodule

// ==== sim/tb_dds_sweep.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the DDS sweep controller
// reads sweep records from the cases file, runs init and
// playback through the top level and decodes sdio/sclk
// back into frames to compare them with the records
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_dds_sweep;

	// a small store so that the credit loop gets exercised
	localparam int SWEEP_DEPTH = 4;
	localparam int IO_RESET_CYCLES = dds_pkg::DEF_IO_RESET_CYCLES;
	localparam int DR_PREP_CYCLES = dds_pkg::DEF_DR_PREP_CYCLES;
	localparam int MAX_CASES = 32;

	logic RABBIT_CLOK;
	logic reset_flag;
	logic host_valid;
	dds_pkg::sweep_record_t host_record;
	logic init_trigger;
	logic sweep_trig;
	logic host_credit;
	logic sdio;
	logic sclk;
	logic io_update;
	logic io_reset;
	logic dr_ctl;
	logic init_busy;
	logic sweep_busy;

	// cases as read from the file
	dds_pkg::sweep_record_t case_rec [MAX_CASES];
	int case_dir [MAX_CASES];
	int case_idle [MAX_CASES];
	int num_cases = 0;

	// decoded frames are right aligned in 184 bits
	logic [183:0] frm_bits [$];
	int frm_len [$];
	logic frm_upd [$];
	logic [183:0] cur_bits = '0;
	int cur_len = 0;
	int gap = 0;
	logic prev_sclk = 1'b0;
	int upd_count = 0;
	int credit_count = 0;

	int errors = 0;
	int test_err = 0;
	int tests = 0;
	int bad_tests = 0;
	int written = 0;
	integer seed = 49526;
	int i;
	int idle;
	int credit_base;

	dds_sweep_top #(
		.SWEEP_DEPTH(SWEEP_DEPTH),
		.IO_RESET_CYCLES(IO_RESET_CYCLES),
		.DR_PREP_CYCLES(DR_PREP_CYCLES)
	) DUT (
		.RABBIT_CLOK(RABBIT_CLOK),
		.reset_flag(reset_flag),
		.host_valid(host_valid),
		.host_record(host_record),
		.init_trigger(init_trigger),
		.sweep_trig(sweep_trig),
		.host_credit(host_credit),
		.sdio(sdio),
		.sclk(sclk),
		.io_update(io_update),
		.io_reset(io_reset),
		.dr_ctl(dr_ctl),
		.init_busy(init_busy),
		.sweep_busy(sweep_busy)
	);

	initial
	begin
		RABBIT_CLOK = 1'b0;
		forever #4 RABBIT_CLOK = ~RABBIT_CLOK;
	end

	// the serial decoder samples on the falling edge where sdio and sclk are settled
	// a frame ends at io_update or after more than two cycles without an sclk rise
	always @(negedge RABBIT_CLOK)
	begin
		if (reset_flag)
		begin
			cur_len = 0;
			gap = 0;
			prev_sclk = 1'b0;
		end
		else
		begin
			if (host_credit)
			begin
				credit_count = credit_count + 1;
			end
			if (sclk && !prev_sclk)
			begin
				cur_bits = {cur_bits[182:0], sdio};
				cur_len = cur_len + 1;
				gap = 0;
			end
			else if (cur_len != 0)
			begin
				gap = gap + 1;
			end
			if (io_update)
			begin
				upd_count = upd_count + 1;
				frm_bits.push_back(cur_bits);
				frm_len.push_back(cur_len);
				frm_upd.push_back(1'b1);
				cur_bits = '0;
				cur_len = 0;
			end
			else if (cur_len != 0 && gap > 2)
			begin
				frm_bits.push_back(cur_bits);
				frm_len.push_back(cur_len);
				frm_upd.push_back(1'b0);
				cur_bits = '0;
				cur_len = 0;
			end
			prev_sclk = sclk;
		end
	end

	task automatic note_mismatch(input string sig, input logic [183:0] exp_v,
		input logic [183:0] act_v);
		$display("FAIL t=%0t %s expected %0h actual %0h", $time, sig, exp_v, act_v);
		errors++;
		test_err++;
	endtask

	task automatic raise_error(input string msg);
		$display("ERROR t=%0t %s", $time, msg);
		errors++;
		test_err++;
	endtask

	// one line per test and a count of the failing ones
	task automatic close_test(input string name);
		if (test_err == 0)
		begin
			$display("test %s ok", name);
		end
		else
		begin
			$display("test %s had %0d errors", name, test_err);
			bad_tests++;
		end
		tests++;
		test_err = 0;
	endtask

	task automatic load_cases();
		int fd;
		int r;
		string line;
		logic [7:0] la;
		logic [7:0] sa;
		logic [7:0] ra;
		logic [31:0] up;
		logic [31:0] lo;
		logic [31:0] ds;
		logic [31:0] inc_s;
		logic [15:0] dr;
		logic [15:0] ir;
		int dir;
		int idl;
		fd = $fopen("sim/sweep_cases.txt", "r");
		if (fd == 0)
		begin
			raise_error("cannot open sim/sweep_cases.txt");
			return;
		end
		while (!$feof(fd) && num_cases < MAX_CASES)
		begin
			r = $fgets(line, fd);
			// lines that start with # describe the columns
			if (r > 0 && line.substr(0, 0) != "#")
			begin
				r = $sscanf(line, "%h %h %h %h %h %h %h %h %h %d %d",
					la, up, lo, sa, ds, inc_s, ra, dr, ir, dir, idl);
				if (r == 11)
				begin
					case_rec[num_cases] = {la, up, lo, sa, ds, inc_s, ra, dr, ir};
					case_dir[num_cases] = dir;
					case_idle[num_cases] = idl;
					num_cases++;
				end
			end
		end
		$fclose(fd);
		if (num_cases == 0)
		begin
			raise_error("the cases file holds no sweep record");
		end
	endtask

	// back to back writes where each one spends a credit the host holds
	task automatic write_records(input int count);
		int k;
		for (k = 0; k < count; k++)
		begin
			if (written - credit_count >= SWEEP_DEPTH)
			begin
				raise_error($sformatf("host has no credit left for case %0d", written));
			end
			else
			begin
				@(posedge RABBIT_CLOK);
				host_valid <= 1'b1;
				host_record <= case_rec[written];
				written++;
			end
		end
		@(posedge RABBIT_CLOK);
		host_valid <= 1'b0;
	endtask

	task automatic pulse_sweep_trig();
		@(posedge RABBIT_CLOK);
		sweep_trig <= 1'b1;
		@(posedge RABBIT_CLOK);
		sweep_trig <= 1'b0;
	endtask

	// the port must stay silent and the player idle
	task automatic expect_quiet(input int cycles);
		int k;
		int active;
		active = 0;
		for (k = 0; k < cycles; k++)
		begin
			@(negedge RABBIT_CLOK);
			if (sclk || sweep_busy)
			begin
				active++;
			end
		end
		if (active != 0)
		begin
			raise_error("serial port or player became active without a stored record");
		end
	endtask

	// the io_reset pulse and the six setup frames with a sweep trigger thrown in
	task automatic run_init();
		int n;
		int k;
		int len;
		logic upd;
		logic [183:0] got;
		logic [183:0] exp_bits [6];
		exp_bits[0] = 184'({dds_pkg::ADDR_RAMP_LIMIT, 64'h0});
		exp_bits[1] = 184'({dds_pkg::ADDR_CFR1, dds_pkg::CFR1_CLEAR_WORD});
		exp_bits[2] = 184'({dds_pkg::ADDR_CFR2, dds_pkg::CFR2_WORD});
		exp_bits[3] = 184'({dds_pkg::ADDR_CFR3, dds_pkg::CFR3_WORD});
		exp_bits[4] = 184'({dds_pkg::ADDR_AUX_DAC, dds_pkg::AUX_DAC_WORD});
		exp_bits[5] = 184'({dds_pkg::ADDR_CFR1, dds_pkg::CFR1_RUN_WORD});
		@(posedge RABBIT_CLOK);
		init_trigger <= 1'b1;
		@(posedge RABBIT_CLOK);
		init_trigger <= 1'b0;
		@(negedge RABBIT_CLOK);
		if (io_reset !== 1'b1)
		begin
			note_mismatch("io_reset", 1, io_reset);
		end
		if (init_busy !== 1'b1)
		begin
			note_mismatch("init_busy", 1, init_busy);
		end
		n = 0;
		while (io_reset === 1'b1 && n < 1000)
		begin
			n++;
			@(negedge RABBIT_CLOK);
		end
		if (n != IO_RESET_CYCLES)
		begin
			note_mismatch("io_reset high cycles", IO_RESET_CYCLES, n);
		end
		// the sweep trigger lands while the first init frame is on the wire
		n = 0;
		while (sclk !== 1'b1 && n < 200)
		begin
			n++;
			@(negedge RABBIT_CLOK);
		end
		if (sclk !== 1'b1)
		begin
			raise_error("no serial clock after the io_reset pulse");
		end
		credit_base = credit_count;
		pulse_sweep_trig();
		n = 0;
		while (init_busy === 1'b1 && n < 5000)
		begin
			n++;
			@(negedge RABBIT_CLOK);
		end
		if (init_busy !== 1'b0)
		begin
			raise_error("init_busy never fell after the init frames");
		end
		if (upd_count != 2)
		begin
			note_mismatch("io_update pulses during init", 2, upd_count);
		end
		if (sweep_busy !== 1'b1)
		begin
			raise_error("the sweep trigger given during init was not accepted");
		end
		// a sweep frame here would have jumped ahead of init
		if (frm_bits.size() != 6)
		begin
			note_mismatch("decoded init frames", 6, frm_bits.size());
		end
		for (k = 0; k < 6 && frm_bits.size() > 0; k++)
		begin
			got = frm_bits.pop_front();
			len = frm_len.pop_front();
			upd = frm_upd.pop_front();
			if (got !== exp_bits[k])
			begin
				note_mismatch($sformatf("sdio init frame %0d", k), exp_bits[k], got);
			end
			if (len != ((k == 0) ? 72 : 40))
			begin
				note_mismatch($sformatf("init frame %0d length", k), (k == 0) ? 72 : 40, len);
			end
			if (upd !== (k >= 4))
			begin
				note_mismatch($sformatf("io_update after init frame %0d", k), k >= 4, upd);
			end
		end
	endtask

	// one sweep from io_update through the end of the dr_ctl preparation
	task automatic check_sweep(input int idx, input int base);
		int n;
		int len;
		logic upd;
		logic upward;
		logic [183:0] got;
		// the cases file gives 1 for an upward sweep
		upward = (case_dir[idx] != 0);
		n = 0;
		do
		begin
			@(negedge RABBIT_CLOK);
			n++;
		end
		while (io_update !== 1'b1 && n < 3000);
		if (io_update !== 1'b1)
		begin
			raise_error($sformatf("no io_update for sweep %0d", idx));
			return;
		end
		@(negedge RABBIT_CLOK);
		if (dr_ctl !== !upward)
		begin
			note_mismatch("dr_ctl", !upward, dr_ctl);
		end
		n = 0;
		while (dr_ctl === !upward && n < 100)
		begin
			n++;
			@(negedge RABBIT_CLOK);
		end
		if (n != DR_PREP_CYCLES)
		begin
			note_mismatch("dr_ctl preparation cycles", DR_PREP_CYCLES, n);
		end
		if (dr_ctl !== upward)
		begin
			note_mismatch("dr_ctl", upward, dr_ctl);
		end
		if (sweep_busy !== 1'b0)
		begin
			note_mismatch("sweep_busy", 0, sweep_busy);
		end
		if (frm_bits.size() == 0)
		begin
			raise_error($sformatf("no frame was decoded for sweep %0d", idx));
		end
		else
		begin
			got = frm_bits.pop_front();
			len = frm_len.pop_front();
			upd = frm_upd.pop_front();
			if (got !== 184'(case_rec[idx]))
			begin
				note_mismatch("sdio sweep frame", case_rec[idx], got);
			end
			if (len != 184)
			begin
				note_mismatch("sweep frame length", 184, len);
			end
			if (upd !== 1'b1)
			begin
				note_mismatch("io_update after sweep frame", 1, upd);
			end
		end
		if (credit_count != base + 1)
		begin
			note_mismatch("host_credit pulses", base + 1, credit_count);
		end
	endtask

	initial
	begin
		reset_flag = 1'b1;
		host_valid = 1'b0;
		host_record = '0;
		init_trigger = 1'b0;
		sweep_trig = 1'b0;
		load_cases();
		repeat (5) @(posedge RABBIT_CLOK);
		reset_flag <= 1'b0;

		// reset values and then a trigger with nothing stored
		@(negedge RABBIT_CLOK);
		if ({sdio, sclk, io_update, io_reset, dr_ctl, init_busy, sweep_busy,
			host_credit} !== 8'h00)
		begin
			note_mismatch("outputs after reset", 0,
				{sdio, sclk, io_update, io_reset, dr_ctl, init_busy, sweep_busy, host_credit});
		end
		pulse_sweep_trig();
		expect_quiet(500);
		close_test("reset");

		// the host starts with a full set of credits
		write_records((SWEEP_DEPTH < num_cases) ? SWEEP_DEPTH : num_cases);
		@(negedge RABBIT_CLOK);
		if (credit_count != 0)
		begin
			note_mismatch("host_credit pulses before any sweep", 0, credit_count);
		end
		close_test("store fill");

		run_init();
		close_test("init");

		for (i = 0; i < num_cases; i++)
		begin
			// the first sweep was already triggered during init
			if (i > 0)
			begin
				idle = (case_idle[i] < 0) ? ({$random(seed)} % 16) : case_idle[i];
				repeat (idle) @(posedge RABBIT_CLOK);
				credit_base = credit_count;
				pulse_sweep_trig();
			end
			check_sweep(i, credit_base);
			// the returned credit lets the host send one more record
			if (written < num_cases)
			begin
				write_records(1);
			end
			close_test($sformatf("sweep %0d", i));
		end

		// one trigger more than the records written
		pulse_sweep_trig();
		expect_quiet(500);
		if (credit_count != num_cases)
		begin
			note_mismatch("total host_credit pulses", num_cases, credit_count);
		end
		close_test("empty store");

		$display("%0d tests, %0d with errors, %0d errors in total", tests, bad_tests, errors);
		if (errors == 0)
		begin
			$display("Verification passed");
		end
		else
		begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== sim/sweep_cases.txt ====
# limit_addr upper_limit lower_limit step_addr dec_step inc_step rate_addr dec_rate inc_rate (hex)
# up (1 when dec_step is all ones), idle cycles before the trigger (-1 random, first case unused)
0b 4ccccccd 19999999 0c ffffffff 0000a7c6 0d 0001 0001 1 0
0b 66666666 33333333 0c 00014f8b ffffffff 0d 0002 0002 0 4
0b 80000000 00000000 0c ffffffff 00029f16 0d 0004 0004 1 -1
0b 12345678 01234567 0c 0000053e ffffffff 0d 0010 0010 0 0
0b 7fffffff 40000000 0c ffffffff 00000001 0d ffff ffff 1 -1
0b 55555555 2aaaaaaa 0c a5a5a5a5 ffffffff 0d 1234 4321 0 7
0b deadbeef 0badf00d 0c ffffffff 5a5a5a5a 0d 00ff ff00 1 -1
0b 0f0f0f0f 00f0f0f0 0c 00000100 ffffffff 0d 8000 0001 0 2
0b c0000000 3fffffff 0c ffffffff 000a7c5b 0d 0101 1010 1 -1
0b 99999999 11111111 0c 0003e800 ffffffff 0d 0020 0040 0 1

// ==== flist.f ====
common/dds_pkg.sv
serial/dds_serial_shifter.sv
serial/serial_port_arbiter.sv
hdl/sweep_store.sv
hdl/init_sequencer.sv
hdl/sweep_player.sv
hdl/dds_sweep_top.sv
sim/tb_dds_sweep.sv
